// File: hw/bn_fixed_pkg.sv
// Fixed-point formats of the batch-norm datapath; scale and shift share the input format
package bn_fixed_pkg;

    // Input samples, scale and shift
    localparam int IN_WIDTH = 8;
    localparam int IN_FRAC = 4;

    // Product plus aligned shift, one guard bit
    localparam int PROD_WIDTH = 17;
    localparam int PROD_FRAC = 8;

    // Output samples
    localparam int OUT_WIDTH = 8;
    localparam int OUT_FRAC = 4;

    // Fraction bits dropped by the output cast
    localparam int CAST_SHIFT = PROD_FRAC - OUT_FRAC;

    // Width of one raw signed product
    localparam int MUL_WIDTH = 2 * IN_WIDTH;

endpackage

// File: hw/bn_cfg_pkg.sv
// Parameter register map; address bit 0 picks scale or shift, upper bits pick the channel
package bn_cfg_pkg;

    typedef enum logic {
        PARAM_SCALE = 1'b0,
        PARAM_SHIFT = 1'b1
    } param_kind_e;

    // Scale of 1.0 in Q4.4
    localparam logic [bn_fixed_pkg::IN_WIDTH-1:0] SCALE_RESET = 16;

    // No offset after reset
    localparam logic [bn_fixed_pkg::IN_WIDTH-1:0] SHIFT_RESET = 0;

endpackage

// File: hw/bn_skid_buffer.sv
// Two-entry valid/ready stage with registered data, valid and ready; payload has no reset
`timescale 1ns/1ps

module bn_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    typedef enum logic [1:0] {
        EMPTY,
        BUSY,
        FULL
    } state_e;

    state_e state;
    state_e next_state;
    logic [WIDTH-1:0] skid_data;
    logic in_fire;
    logic out_fire;
    logic load_main;
    logic load_skid;
    logic unskid;

    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_comb begin
        next_state = state;
        load_main = 1'b0;
        load_skid = 1'b0;
        unskid = 1'b0;
        case (state)
            EMPTY: begin
                if (in_fire) begin
                    next_state = BUSY;
                    load_main = 1'b1;
                end
            end
            BUSY: begin
                if (in_fire && out_fire) begin
                    load_main = 1'b1;
                end else if (in_fire) begin
                    // Consumer stalled, park the new beat
                    next_state = FULL;
                    load_skid = 1'b1;
                end else if (out_fire) begin
                    next_state = EMPTY;
                end
            end
            FULL: begin
                if (out_fire) begin
                    next_state = BUSY;
                    unskid = 1'b1;
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
            in_ready <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            state <= next_state;
            in_ready <= (next_state != FULL);
            out_valid <= (next_state != EMPTY);
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            out_data <= in_data;
        end else if (unskid) begin
            out_data <= skid_data;
        end
        if (load_skid) begin
            skid_data <= in_data;
        end
    end

endmodule

// File: hw/bn_fixed_cast.sv
// One-lane floor and saturate from the product format to signed Q4.4; purely combinational
`timescale 1ns/1ps

module bn_fixed_cast (
    input  logic signed [bn_fixed_pkg::PROD_WIDTH-1:0] in_data,
    output logic        [bn_fixed_pkg::OUT_WIDTH-1:0]  out_data
);

    localparam int PW = bn_fixed_pkg::PROD_WIDTH;
    localparam int OW = bn_fixed_pkg::OUT_WIDTH;

    localparam logic signed [PW-1:0] SAT_MAX = (2 ** (OW - 1)) - 1;
    localparam logic signed [PW-1:0] SAT_MIN = -(2 ** (OW - 1));

    logic signed [PW-1:0] floored;

    // Arithmetic shift rounds toward minus infinity
    assign floored = in_data >>> bn_fixed_pkg::CAST_SHIFT;

    always_comb begin
        if (floored > SAT_MAX) begin
            out_data = SAT_MAX[OW-1:0];
        end else if (floored < SAT_MIN) begin
            out_data = SAT_MIN[OW-1:0];
        end else begin
            out_data = floored[OW-1:0];
        end
    end

endmodule

// File: hw/bn_param_regs.sv
// Per-channel scale/shift registers, write-only; writes to channels past NUM_CHANNELS are dropped
`timescale 1ns/1ps

module bn_param_regs #(
    parameter int NUM_CHANNELS = 2,
    localparam int CH_BITS = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cfg_wr,
    input  logic [CH_BITS:0]                    cfg_addr,
    input  logic [bn_fixed_pkg::IN_WIDTH-1:0]   cfg_wdata,
    input  logic [CH_BITS-1:0]                  channel,
    output logic [bn_fixed_pkg::IN_WIDTH-1:0]   scale,
    output logic [bn_fixed_pkg::IN_WIDTH-1:0]   shift
);

    logic [bn_fixed_pkg::IN_WIDTH-1:0] scale_regs [NUM_CHANNELS];
    logic [bn_fixed_pkg::IN_WIDTH-1:0] shift_regs [NUM_CHANNELS];
    logic [CH_BITS-1:0] wr_channel;
    bn_cfg_pkg::param_kind_e wr_kind;
    logic wr_in_range;

    // Address decode
    assign wr_kind = bn_cfg_pkg::param_kind_e'(cfg_addr[0]);
    assign wr_channel = cfg_addr[CH_BITS:1];
    assign wr_in_range = (int'(wr_channel) < NUM_CHANNELS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                scale_regs[i] <= bn_cfg_pkg::SCALE_RESET;
                shift_regs[i] <= bn_cfg_pkg::SHIFT_RESET;
            end
        end else if (cfg_wr && wr_in_range) begin
            case (wr_kind)
                bn_cfg_pkg::PARAM_SCALE: scale_regs[wr_channel] <= cfg_wdata;
                bn_cfg_pkg::PARAM_SHIFT: shift_regs[wr_channel] <= cfg_wdata;
                default: ;
            endcase
        end
    end

    // Read for the channel the pipe is on
    assign scale = scale_regs[channel];
    assign shift = shift_regs[channel];

endmodule

// File: hw/bn_affine_pipe.sv
// Three-stage per-lane y = x*scale + shift; tiles in raster order, no partial tiles
`timescale 1ns/1ps

module bn_affine_pipe #(
    parameter int TOTAL_DIM0 = 4,
    parameter int TOTAL_DIM1 = 4,
    parameter int COMPUTE_DIM0 = 2,
    parameter int COMPUTE_DIM1 = 2,
    parameter int NUM_CHANNELS = 2,
    localparam int LANES = COMPUTE_DIM0 * COMPUTE_DIM1,
    localparam int CH_BITS = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [LANES*bn_fixed_pkg::IN_WIDTH-1:0]     in_data,
    input  logic                                        in_valid,
    output logic                                        in_ready,
    output logic [LANES*bn_fixed_pkg::OUT_WIDTH-1:0]    out_data,
    output logic                                        out_valid,
    input  logic                                        out_ready,
    output logic [CH_BITS-1:0]                          channel,
    input  logic [bn_fixed_pkg::IN_WIDTH-1:0]           scale,
    input  logic [bn_fixed_pkg::IN_WIDTH-1:0]           shift
);

    localparam int IW = bn_fixed_pkg::IN_WIDTH;
    localparam int MW = bn_fixed_pkg::MUL_WIDTH;
    localparam int OW = bn_fixed_pkg::OUT_WIDTH;
    localparam int BEATS_PER_CH = (TOTAL_DIM0 / COMPUTE_DIM0) * (TOTAL_DIM1 / COMPUTE_DIM1);
    localparam int CNT_BITS = (BEATS_PER_CH > 1) ? $clog2(BEATS_PER_CH) : 1;
    localparam int S0_WIDTH = LANES * IW + 2 * IW;
    localparam int S1_WIDTH = LANES * MW + IW;

    logic [CNT_BITS-1:0] beat_cnt;
    logic in_fire;

    logic [S0_WIDTH-1:0] s0_bus;
    logic s0_valid;
    logic s0_ready;
    logic [LANES*IW-1:0] s0_data;
    logic signed [IW-1:0] s0_scale;
    logic signed [IW-1:0] s0_shift;

    logic [LANES*MW-1:0] prod_flat;
    logic [S1_WIDTH-1:0] s1_bus;
    logic s1_valid;
    logic s1_ready;
    logic [LANES*MW-1:0] s1_prod;
    logic signed [IW-1:0] s1_shift;
    logic signed [bn_fixed_pkg::PROD_WIDTH-1:0] shift_ext;

    logic [LANES*OW-1:0] cast_flat;

    assign in_fire = in_valid && in_ready;

    // Channel advances after each full feature map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            channel <= '0;
        end else if (in_fire) begin
            if (beat_cnt == CNT_BITS'(BEATS_PER_CH - 1)) begin
                beat_cnt <= '0;
                if (channel == CH_BITS'(NUM_CHANNELS - 1)) begin
                    channel <= '0;
                end else begin
                    channel <= channel + 1'b1;
                end
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Stage 0 takes the tile with this channel's parameters
    bn_skid_buffer #(
        .WIDTH(S0_WIDTH)
    ) u_stage0 (
        .clk(clk),
        .rst_n(rst_n),
        .in_data({in_data, scale, shift}),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(s0_bus),
        .out_valid(s0_valid),
        .out_ready(s0_ready)
    );

    assign s0_data = s0_bus[S0_WIDTH-1 -: LANES*IW];
    assign s0_scale = s0_bus[2*IW-1 -: IW];
    assign s0_shift = s0_bus[IW-1:0];

    bn_skid_buffer #(
        .WIDTH(S1_WIDTH)
    ) u_stage1 (
        .clk(clk),
        .rst_n(rst_n),
        .in_data({prod_flat, s0_shift}),
        .in_valid(s0_valid),
        .in_ready(s0_ready),
        .out_data(s1_bus),
        .out_valid(s1_valid),
        .out_ready(s1_ready)
    );

    assign s1_prod = s1_bus[S1_WIDTH-1 -: LANES*MW];
    assign s1_shift = s1_bus[IW-1:0];
    assign shift_ext = s1_shift;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [IW-1:0] x;
        logic signed [MW-1:0] prod;
        logic signed [MW-1:0] prod_q;
        logic signed [bn_fixed_pkg::PROD_WIDTH-1:0] sum;

        assign x = s0_data[i*IW +: IW];
        assign prod = x * s0_scale;
        assign prod_flat[i*MW +: MW] = prod;

        // Shift moved up to the product's binary point
        assign prod_q = s1_prod[i*MW +: MW];
        assign sum = prod_q + (shift_ext <<< bn_fixed_pkg::IN_FRAC);

        bn_fixed_cast u_cast (
            .in_data(sum),
            .out_data(cast_flat[i*OW +: OW])
        );
    end

    bn_skid_buffer #(
        .WIDTH(LANES * OW)
    ) u_stage2 (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(cast_flat),
        .in_valid(s1_valid),
        .in_ready(s1_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: hw/bn_top.sv
// Batch-norm top; lane 0 sits in the low bits of the stream buses, config is write-only
`timescale 1ns/1ps

module bn_top #(
    parameter int TOTAL_DIM0 = 4,
    parameter int TOTAL_DIM1 = 4,
    parameter int COMPUTE_DIM0 = 2,
    parameter int COMPUTE_DIM1 = 2,
    parameter int NUM_CHANNELS = 2,
    localparam int LANES = COMPUTE_DIM0 * COMPUTE_DIM1,
    localparam int CH_BITS = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [LANES*bn_fixed_pkg::IN_WIDTH-1:0]     in_data,
    input  logic                                        in_valid,
    output logic                                        in_ready,
    output logic [LANES*bn_fixed_pkg::OUT_WIDTH-1:0]    out_data,
    output logic                                        out_valid,
    input  logic                                        out_ready,
    input  logic                                        cfg_wr,
    input  logic [CH_BITS:0]                            cfg_addr,
    input  logic [bn_fixed_pkg::IN_WIDTH-1:0]           cfg_wdata
);

    logic [CH_BITS-1:0] channel;
    logic [bn_fixed_pkg::IN_WIDTH-1:0] scale;
    logic [bn_fixed_pkg::IN_WIDTH-1:0] shift;

    bn_param_regs #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) u_regs (
        .clk(clk),
        .rst_n(rst_n),
        .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .channel(channel),
        .scale(scale),
        .shift(shift)
    );

    bn_affine_pipe #(
        .TOTAL_DIM0(TOTAL_DIM0),
        .TOTAL_DIM1(TOTAL_DIM1),
        .COMPUTE_DIM0(COMPUTE_DIM0),
        .COMPUTE_DIM1(COMPUTE_DIM1),
        .NUM_CHANNELS(NUM_CHANNELS)
    ) u_pipe (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .channel(channel),
        .scale(scale),
        .shift(shift)
    );

endmodule

// File: tb/bn_model.svh
// Reference model for bn_top; lanes are signed Q4.4, channels advance per full feature map
`ifndef BN_MODEL_SVH
`define BN_MODEL_SVH

// Channel that the n-th accepted beat belongs to
function automatic int channel_of_beat(input int beat, input int beats_per_ch, input int num_ch);
    return (beat % (beats_per_ch * num_ch)) / beats_per_ch;
endfunction

// x * scale + shift, floored to 4 fraction bits and clamped to 8 bits
function automatic logic [7:0] lane_result(input logic [7:0] x, input logic [7:0] scale,
                                           input logic [7:0] shift);
    int acc;
    int q;
    // Product carries 8 fraction bits, shift only 4
    acc = int'($signed(x)) * int'($signed(scale)) + int'($signed(shift)) * 16;
    if (acc >= 0) begin
        q = acc / 16;
    end else begin
        q = -((-acc + 15) / 16);
    end
    if (q > 127) begin
        q = 127;
    end else if (q < -128) begin
        q = -128;
    end
    return 8'(q);
endfunction

`endif

// File: tb/bn_tb.sv
// Directed tests for bn_top at default sizes of 4 lanes, 2 channels and 4 beats per channel
`timescale 1ns/1ps

module bn_tb;

    localparam int LANES = 4;
    localparam int NUM_CHANNELS = 2;
    localparam int BEATS_PER_CH = 4;
    localparam int FRAME = NUM_CHANNELS * BEATS_PER_CH;
    localparam int TILE_W = LANES * bn_fixed_pkg::IN_WIDTH;
    localparam int TIMEOUT = 2000;

    `include "bn_model.svh"

    logic clk = 1'b0;
    logic rst_n;
    logic [TILE_W-1:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [TILE_W-1:0] out_data;
    logic out_valid;
    logic out_ready;
    logic cfg_wr;
    logic [1:0] cfg_addr;
    logic [bn_fixed_pkg::IN_WIDTH-1:0] cfg_wdata;

    logic [7:0] model_scale [NUM_CHANNELS];
    logic [7:0] model_shift [NUM_CHANNELS];
    logic [TILE_W-1:0] expect_q [$];
    int beat_idx;
    int checked;
    int errors;
    logic random_ready;
    logic random_gaps;

    always #5 clk = ~clk;

    bn_top UUT (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata)
    );

    // Scoreboard on every output transfer
    always @(posedge clk) begin : scoreboard
        logic [TILE_W-1:0] head;
        if (rst_n && out_valid && out_ready) begin
            assert (expect_q.size() != 0) else begin
                $display("Output beat arrived while no beat was expected");
                errors++;
            end
            if (expect_q.size() != 0) begin
                head = expect_q.pop_front();
                checked++;
                assert (out_data === head) else begin
                    $display("ERROR: out_data expected %h actual %h", head, out_data);
                    errors++;
                end
            end
        end
    end

    // Random consumer stalls
    always begin : ready_gen
        logic rnd;
        @(posedge clk);
        rnd = random_ready;
        #1;
        if (rnd) begin
            out_ready = 1'($urandom_range(0, 1));
        end
    end

    function automatic logic [TILE_W-1:0] tile_result(input logic [TILE_W-1:0] tile, input int ch);
        logic [TILE_W-1:0] res;
        for (int i = 0; i < LANES; i++) begin
            res[i*8 +: 8] = lane_result(tile[i*8 +: 8], model_scale[ch], model_shift[ch]);
        end
        return res;
    endfunction

    // Expected value is taken with the parameters valid at the accept edge
    task automatic send_beat(input logic [TILE_W-1:0] tile);
        int waited;
        logic accepted;
        if (random_gaps) begin
            in_valid = 1'b0;
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk);
                #1;
            end
        end
        in_data = tile;
        in_valid = 1'b1;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end
        if (accepted) begin
            expect_q.push_back(tile_result(tile, channel_of_beat(beat_idx, BEATS_PER_CH,
                                                                 NUM_CHANNELS)));
            beat_idx++;
        end else begin
            $display("Timeout: input beat %0d was never accepted", beat_idx);
            errors++;
        end
        #1;
    endtask

    task automatic write_param(input int ch, input bn_cfg_pkg::param_kind_e kind,
                               input logic [7:0] value);
        cfg_addr = 2'(ch * 2 + int'(kind));
        cfg_wdata = value;
        cfg_wr = 1'b1;
        @(posedge clk);
        if (kind == bn_cfg_pkg::PARAM_SCALE) begin
            model_scale[ch] = value;
        end else begin
            model_shift[ch] = value;
        end
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        in_valid = 1'b0;
        waited = 0;
        while (expect_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("Timeout: %0d expected beats never came out", expect_q.size());
            errors++;
        end
    endtask

    task automatic passthrough_after_reset();
        repeat (3 * FRAME) send_beat($urandom);
        wait_drain();
    endtask

    task automatic latency_single_beat();
        int edges;
        logic seen;
        send_beat(32'h7f80_10f1);
        in_valid = 1'b0;
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            seen = out_valid;
        end
        #1;
        if (!seen) begin
            $display("Timeout: out_valid never rose for the latency beat");
            errors++;
        end else begin
            assert (edges == 3) else begin
                $display("ERROR: out_valid latency expected %h actual %h", 3, edges);
                errors++;
            end
        end
        wait_drain();
    endtask

    task automatic channel_parameters();
        write_param(0, bn_cfg_pkg::PARAM_SCALE, 8'h18);
        write_param(0, bn_cfg_pkg::PARAM_SHIFT, 8'hf8);
        write_param(1, bn_cfg_pkg::PARAM_SCALE, 8'hf0);
        write_param(1, bn_cfg_pkg::PARAM_SHIFT, 8'h14);
        repeat (2 * FRAME) send_beat($urandom);
        wait_drain();
    endtask

    task automatic round_and_saturate();
        logic [TILE_W-1:0] tiles [2];
        tiles[0] = {8'h7f, 8'h80, 8'hff, 8'hfd};
        tiles[1] = {8'h40, 8'h81, 8'h01, 8'hf1};
        // Half scale floors negative odd inputs and large scale clamps both ends
        write_param(0, bn_cfg_pkg::PARAM_SCALE, 8'h08);
        write_param(0, bn_cfg_pkg::PARAM_SHIFT, 8'hff);
        write_param(1, bn_cfg_pkg::PARAM_SCALE, 8'h7f);
        write_param(1, bn_cfg_pkg::PARAM_SHIFT, 8'h80);
        for (int i = 0; i < FRAME; i++) begin
            send_beat(tiles[i % 2]);
        end
        wait_drain();
    endtask

    task automatic random_backpressure();
        random_gaps = 1'b1;
        random_ready = 1'b1;
        repeat (200) send_beat($urandom);
        random_gaps = 1'b0;
        wait_drain();
        random_ready = 1'b0;
        @(posedge clk);
        #1;
        out_ready = 1'b1;
    endtask

    task automatic midstream_scale_write();
        int ch;
        // Start on a channel boundary so the last four beats share one channel
        repeat ((BEATS_PER_CH - beat_idx % BEATS_PER_CH) % BEATS_PER_CH) send_beat($urandom);
        wait_drain();
        out_ready = 1'b0;
        // With the output stalled the fifth and sixth beats stay in stage 0
        repeat (6) send_beat($urandom);
        in_valid = 1'b0;
        ch = channel_of_beat(beat_idx, BEATS_PER_CH, NUM_CHANNELS);
        write_param(ch, bn_cfg_pkg::PARAM_SCALE, 8'h28);
        out_ready = 1'b1;
        repeat (2) send_beat($urandom);
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'hf62c_d43d));
        rst_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        random_ready = 1'b0;
        random_gaps = 1'b0;
        beat_idx = 0;
        checked = 0;
        errors = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            model_scale[c] = bn_cfg_pkg::SCALE_RESET;
            model_shift[c] = bn_cfg_pkg::SHIFT_RESET;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (in_ready && !out_valid) else begin
            $display("Stream handshake was not idle after reset");
            errors++;
        end
        passthrough_after_reset();
        latency_single_beat();
        channel_parameters();
        round_and_saturate();
        random_backpressure();
        midstream_scale_write();
        assert (checked == beat_idx) else begin
            $display("ERROR: output beat count expected %h actual %h", beat_idx, checked);
            errors++;
        end
        $display("Summary: %0d beats checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+tb
hw/bn_fixed_pkg.sv
hw/bn_cfg_pkg.sv
hw/bn_skid_buffer.sv
hw/bn_fixed_cast.sv
hw/bn_param_regs.sv
hw/bn_affine_pipe.sv
hw/bn_top.sv
tb/bn_tb.sv

// File: Makefile
TOP = bn_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
